// ==== cache_pkg.sv ====
package cache_pkg;

    localparam int num_ways = 4;
    localparam int num_sets = 16;
    localparam int addr_w   = 12;
    localparam int tag_w    = 8;
    localparam int index_w  = 4;
    localparam int data_w   = 32;
    localparam int plru_w   = 3;

    typedef logic [$clog2(num_ways)-1:0] way_t;

    // bit 2 picks the pair, bit 1 the way in pair 0/1, bit 0 the way in pair 2/3.
    typedef logic [plru_w-1:0] plru_t;

    // the raw view goes to memory, the split view feeds the arrays.
    typedef union packed {
        logic [addr_w-1:0] raw;
        struct packed {
            logic [tag_w-1:0]   tag;
            logic [index_w-1:0] index;
        } f;
    } cache_addr_u;

    typedef struct packed {
        logic        valid;
        cache_addr_u addr;
    } cache_req_t;

    typedef struct packed {
        logic              valid;
        logic              hit;   // clear when the word came from memory.
        logic [data_w-1:0] data;
    } cache_rsp_t;

    typedef struct packed {
        logic              valid;
        logic [addr_w-1:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic              valid;
        logic [data_w-1:0] data;
    } mem_rsp_t;

endpackage : cache_pkg

// ==== plru.sv ====
`timescale 1ns/1ps

module plru import cache_pkg::*; (
    input  logic  update,
    input  logic  replace,
    input  way_t  way,
    input  plru_t state,
    output way_t  victim,
    output plru_t next_state,
    output logic  write
);

    way_t used_way;

    // follow the tree bits down to the least recently used way.
    always_comb begin
        case (state)
            3'b000, 3'b001: begin
                victim = 2'd0;
            end
            3'b010, 3'b011: begin
                victim = 2'd1;
            end
            3'b100, 3'b110: begin
                victim = 2'd2;
            end
            default: begin
                victim = 2'd3;  // states 101 and 111.
            end
        endcase
    end

    // on a refill the way being used is the one just picked for eviction.
    assign used_way = replace ? victim : way;

    // point both tree levels on the used path away from it.
    // the bit of the other pair is left alone.
    always_comb begin
        case (used_way)
            2'd0: begin
                next_state = {2'b11, state[0]};
            end
            2'd1: begin
                next_state = {2'b10, state[0]};
            end
            2'd2: begin
                next_state = {1'b0, state[1], 1'b1};
            end
            default: begin
                next_state = {1'b0, state[1], 1'b0};
            end
        endcase
    end

    assign write = update;

endmodule : plru

// ==== lru_array.sv ====
`timescale 1ns/1ps

module lru_array import cache_pkg::*; (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               flush,
    input  logic [index_w-1:0] index,
    input  logic               write,
    input  plru_t              next_state,
    output plru_t              state
);

    plru_t [num_sets-1:0] state_q;

    // a cleared state makes the fill order way 0, 2, 1, 3.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= '0;
        end else if (flush) begin
            state_q <= '0;
        end else if (write) begin
            state_q[index] <= next_state;
        end
    end

    assign state = state_q[index];  // read in the same cycle as the lookup.

endmodule : lru_array

// ==== tag_array.sv ====
`timescale 1ns/1ps

module tag_array import cache_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        flush,
    input  cache_addr_u addr,
    input  logic        fill,
    input  way_t        fill_way,
    output logic        hit,
    output way_t        hit_way
);

    logic [num_sets-1:0][num_ways-1:0] valid_q;
    logic [tag_w-1:0]                  tag_q [num_sets][num_ways];
    logic [num_ways-1:0]               match;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (flush) begin
            valid_q <= '0;
        end else if (fill) begin
            valid_q[addr.f.index][fill_way] <= 1'b1;
        end
    end

    // tags are only looked at behind a set valid bit.
    always_ff @(posedge clk) begin
        if (fill) begin
            tag_q[addr.f.index][fill_way] <= addr.f.tag;
        end
    end

    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            match[w] = valid_q[addr.f.index][w]
                       && (tag_q[addr.f.index][w] == addr.f.tag);
        end
    end

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (match[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign hit = |match;

    // the controller only fills after a miss, so a tag never lands twice in a set.
    assert property (@(posedge clk) disable iff (!arst_n) $onehot0(match))
        else $error("tag_array: more than one way matches in set %0d", addr.f.index);

endmodule : tag_array

// ==== data_array.sv ====
`timescale 1ns/1ps

module data_array import cache_pkg::*; (
    input  logic               clk,
    input  logic [index_w-1:0] index,
    input  logic               fill,
    input  way_t               fill_way,
    input  logic [data_w-1:0]  fill_data,
    input  way_t               read_way,
    output logic [data_w-1:0]  read_data
);

    logic [data_w-1:0] word_q [num_sets][num_ways];

    always_ff @(posedge clk) begin
        if (fill) begin
            word_q[index][fill_way] <= fill_data;
        end
    end

    assign read_data = word_q[index][read_way];

endmodule : data_array

// ==== cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl import cache_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  cache_req_t        req,
    input  logic              flush,
    output cache_rsp_t        rsp,
    output mem_req_t          mem_req,
    input  mem_rsp_t          mem_rsp,
    output cache_addr_u       addr,
    input  logic              hit,
    input  way_t              hit_way,
    input  way_t              victim,
    input  logic [data_w-1:0] read_data,
    output logic              plru_update,
    output logic              plru_replace,
    output way_t              plru_way,
    output logic              fill,
    output way_t              fill_way,
    output logic [data_w-1:0] fill_data,
    output logic              flush_arrays
);

    typedef enum logic [1:0] {
        st_idle,
        st_lookup,
        st_wait,
        st_respond
    } state_t;

    state_t            state_q;
    state_t            state_d;
    cache_addr_u       addr_q;
    way_t              way_q;        // hit way, or the victim on a miss.
    logic              hit_q;
    logic              issue_q;
    logic              mem_valid_q;
    logic              rsp_valid_q;
    logic [data_w-1:0] rsp_data_q;
    logic              mem_done;

    assign mem_done = (state_q == st_wait) && mem_rsp.valid;

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (req.valid) begin
                    state_d = st_lookup;
                end
            end
            st_lookup: begin
                state_d = hit ? st_respond : st_wait;
            end
            st_wait: begin
                if (mem_rsp.valid) begin
                    state_d = st_respond;
                end
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    // a miss goes through issue_q first, so the memory strobe comes out
    // two cycles after the request, like the response does on a hit.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q     <= st_idle;
            issue_q     <= 1'b0;
            mem_valid_q <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            issue_q     <= (state_q == st_lookup) && !hit;
            mem_valid_q <= issue_q;
            rsp_valid_q <= (state_q == st_respond);
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == st_idle) && req.valid) begin
            addr_q <= req.addr;
        end
        if (state_q == st_lookup) begin
            hit_q <= hit;
            way_q <= hit ? hit_way : victim;
        end
        // the fill has landed by now, so a miss reads back the memory word.
        if (state_q == st_respond) begin
            rsp_data_q <= read_data;
        end
    end

    assign addr         = addr_q;
    assign mem_req      = '{valid: mem_valid_q, addr: addr_q.raw};
    assign rsp          = '{valid: rsp_valid_q, hit: hit_q, data: rsp_data_q};
    assign plru_update  = ((state_q == st_lookup) && hit) || mem_done;
    assign plru_replace = mem_done;  // the refill takes the way the tree points at.
    assign plru_way     = (state_q == st_lookup) ? hit_way : way_q;
    assign fill         = mem_done;
    assign fill_way     = way_q;
    assign fill_data    = mem_rsp.data;
    assign flush_arrays = flush && (state_q == st_idle);

    // there is a single miss buffer, so only one request may be in flight.
    assert property (@(posedge clk) disable iff (!arst_n)
        req.valid |-> (state_q == st_idle))
        else $error("cache_ctrl: request while a previous one is in flight");

    assert property (@(posedge clk) disable iff (!arst_n)
        mem_rsp.valid |-> (state_q == st_wait))
        else $error("cache_ctrl: memory response with no memory request open");

    assert property (@(posedge clk) disable iff (!arst_n)
        flush |-> (state_q == st_idle))
        else $error("cache_ctrl: flush while a request is in flight");

endmodule : cache_ctrl

// ==== cache_top.sv ====
`timescale 1ns/1ps

module cache_top import cache_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  cache_req_t req,
    input  logic       flush,
    output cache_rsp_t rsp,
    output mem_req_t   mem_req,
    input  mem_rsp_t   mem_rsp
);

    cache_addr_u       addr;
    logic              hit;
    way_t              hit_way;
    way_t              victim;
    logic [data_w-1:0] read_data;
    logic              plru_update;
    logic              plru_replace;
    way_t              plru_way;
    logic              fill;
    way_t              fill_way;
    logic [data_w-1:0] fill_data;
    logic              flush_arrays;
    plru_t             lru_state;
    plru_t             lru_next;
    logic              lru_write;

    cache_ctrl ctrl_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .req          (req),
        .flush        (flush),
        .rsp          (rsp),
        .mem_req      (mem_req),
        .mem_rsp      (mem_rsp),
        .addr         (addr),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim       (victim),
        .read_data    (read_data),
        .plru_update  (plru_update),
        .plru_replace (plru_replace),
        .plru_way     (plru_way),
        .fill         (fill),
        .fill_way     (fill_way),
        .fill_data    (fill_data),
        .flush_arrays (flush_arrays)
    );

    tag_array tag_array_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .flush    (flush_arrays),
        .addr     (addr),
        .fill     (fill),
        .fill_way (fill_way),
        .hit      (hit),
        .hit_way  (hit_way)
    );

    // the latched way serves the fill as well as the read of the response word.
    data_array data_array_inst (
        .clk       (clk),
        .index     (addr.f.index),
        .fill      (fill),
        .fill_way  (fill_way),
        .fill_data (fill_data),
        .read_way  (fill_way),
        .read_data (read_data)
    );

    lru_array lru_array_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .flush      (flush_arrays),
        .index      (addr.f.index),
        .write      (lru_write),
        .next_state (lru_next),
        .state      (lru_state)
    );

    plru plru_inst (
        .update     (plru_update),
        .replace    (plru_replace),
        .way        (plru_way),
        .state      (lru_state),
        .victim     (victim),
        .next_state (lru_next),
        .write      (lru_write)
    );

endmodule : cache_top

// ==== cache_tb.sv ====
`timescale 1ns/1ps

module cache_tb import cache_pkg::*; ();

    localparam int clk_period   = 4;
    localparam int reset_cycles = 8;
    localparam int max_lat      = 6;
    localparam int n_random     = 200;
    localparam int resp_limit   = max_lat + 8;

    typedef struct packed {
        logic        is_flush;
        cache_addr_u addr;
        logic [3:0]  test;
    } row_t;

    logic       clk = 1'b0;
    logic       arst_n;
    cache_req_t req;
    logic       flush;
    cache_rsp_t rsp;
    mem_req_t   mem_req;
    mem_rsp_t   mem_rsp = '0;

    row_t        rows[$];
    logic        table_built = 1'b0;
    int          cyc = 0;
    logic [31:0] addr_seed = 32'd53367;
    logic [31:0] lat_seed = 32'd53367;

    // memory traffic as seen by the memory model.
    int                mem_req_count = 0;
    int                mem_req_cyc = 0;
    int                mem_rsp_cyc = 0;
    logic [addr_w-1:0] mem_req_addr = '0;
    logic              mem_busy = 1'b0;
    int                mem_wait = 0;
    logic [addr_w-1:0] mem_addr = '0;

    logic              model_valid [num_sets][num_ways];
    logic [tag_w-1:0]  model_tag [num_sets][num_ways];
    plru_t             model_plru [num_sets];

    logic [3:0] cur_test;
    int         test_rows = 0;
    int         test_errors = 0;
    int         tests_run = 0;
    int         tests_failed = 0;
    int         errors = 0;

    cache_top cache_top_inst (
        .clk     (clk),
        .arst_n  (arst_n),
        .req     (req),
        .flush   (flush),
        .rsp     (rsp),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    always #(clk_period / 2) clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [data_w-1:0] mem_word(input logic [addr_w-1:0] a);
        return xorshift(xorshift({a, 20'h5bd1e}));
    endfunction

    // bit 2 picks the pair, then bit 1 or bit 0 picks the way in it.
    function automatic way_t pick_victim(input plru_t s);
        if (!s[2]) begin
            return s[1] ? 2'd1 : 2'd0;
        end
        return s[0] ? 2'd3 : 2'd2;
    endfunction

    function automatic plru_t touch_way(input plru_t s, input way_t w);
        if (!w[1]) begin
            return {1'b1, ~w[0], s[0]};
        end
        return {1'b0, s[1], ~w[0]};
    endfunction

    task automatic clear_model();
        for (int s = 0; s < num_sets; s++) begin
            model_plru[s] = '0;
            for (int w = 0; w < num_ways; w++) begin
                model_valid[s][w] = 1'b0;
            end
        end
    endtask

    task automatic predict_read(input cache_addr_u a, output logic hit);
        way_t w;
        hit = 1'b0;
        w   = '0;
        for (int i = 0; i < num_ways; i++) begin
            if (model_valid[a.f.index][i] && model_tag[a.f.index][i] == a.f.tag) begin
                hit = 1'b1;
                w   = way_t'(i);
            end
        end
        if (!hit) begin
            w = pick_victim(model_plru[a.f.index]);
            model_valid[a.f.index][w] = 1'b1;
            model_tag[a.f.index][w]   = a.f.tag;
        end
        model_plru[a.f.index] = touch_way(model_plru[a.f.index], w);
    endtask

    task automatic add_read(input logic [addr_w-1:0] a, input logic [3:0] t);
        rows.push_back('{is_flush: 1'b0, addr: a, test: t});
    endtask

    task automatic add_flush(input logic [3:0] t);
        rows.push_back('{is_flush: 1'b1, addr: '0, test: t});
    endtask

    task automatic build_table();
        logic [3:0] idx;
        logic [7:0] tg;
        add_read(12'h123, 4'd1);
        add_read(12'h123, 4'd2);
        for (int n = 1; n <= 5; n++) add_read({8'(n), 4'h5}, 4'd3);  // five tags in set 5.
        for (int n = 1; n <= 4; n++) add_read({8'(n), 4'h5}, 4'd3);
        for (int n = 1; n <= 4; n++) add_read({8'hA0 + 8'(n), 4'h9}, 4'd4);
        add_read(12'hA19, 4'd4);  // way 0 gets used, so way 2 is the next victim.
        add_read(12'hA59, 4'd4);
        add_read(12'hA19, 4'd4);
        add_read(12'hA39, 4'd4);
        add_read(12'hA29, 4'd4);
        add_flush(4'd5);
        add_read(12'h123, 4'd5);
        for (int n = 1; n <= 4; n++) add_read({8'hA0 + 8'(n), 4'h9}, 4'd5);
        add_read(12'hA19, 4'd5);
        for (int n = 0; n < n_random; n++) begin
            addr_seed = xorshift(addr_seed);
            case (addr_seed % 3)
                0: idx = 4'd3;
                1: idx = 4'd7;
                default: idx = 4'd12;
            endcase
            addr_seed = xorshift(addr_seed);
            tg = 8'h40 + 8'(addr_seed % 6);
            add_read({tg, idx}, 4'd6);
        end
    endtask

    task automatic count_error();
        errors++;
        test_errors++;
    endtask

    task automatic report_test();
        if (test_rows > 0) begin
            $display("test %0d: %0d rows, %0d errors", cur_test, test_rows, test_errors);
            tests_run++;
            if (test_errors != 0) tests_failed++;
        end
        test_rows   = 0;
        test_errors = 0;
    endtask

    // the backing memory answers each request after 1 to max_lat cycles.
    always @(posedge clk) begin
        int lat;
        mem_rsp <= '0;
        if (mem_req.valid) begin
            mem_req_count <= mem_req_count + 1;
            mem_req_addr  <= mem_req.addr;
            mem_req_cyc   <= cyc;
            lat_seed = xorshift(lat_seed);
            lat      = int'(lat_seed % max_lat) + 1;
            if (lat == 1) begin
                mem_rsp     <= '{valid: 1'b1, data: mem_word(mem_req.addr)};
                mem_rsp_cyc <= cyc;
            end else begin
                mem_busy <= 1'b1;
                mem_wait <= lat - 2;
                mem_addr <= mem_req.addr;
            end
        end else if (mem_busy) begin
            if (mem_wait == 0) begin
                mem_rsp     <= '{valid: 1'b1, data: mem_word(mem_addr)};
                mem_rsp_cyc <= cyc;
                mem_busy    <= 1'b0;
            end else begin
                mem_wait <= mem_wait - 1;
            end
        end
    end

    initial begin
        int                waited;
        int                c0;
        int                mem_before;
        logic              exp_hit;
        logic [data_w-1:0] exp_data;
        logic              aborted;
        row_t              row;
        arst_n  = 1'b0;
        req     = '0;
        flush   = 1'b0;
        aborted = 1'b0;
        clear_model();
        build_table();
        table_built = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        cur_test = rows[0].test;
        for (int r = 0; r < rows.size() && !aborted; r++) begin
            row = rows[r];
            if (row.test != cur_test) begin
                report_test();
                cur_test = row.test;
            end
            test_rows++;
            if (row.is_flush) begin
                @(posedge clk);
                flush <= 1'b1;  // the next read goes out on the very next edge.
                clear_model();
            end else begin
                @(posedge clk);
                flush      <= 1'b0;
                req        <= '{valid: 1'b1, addr: row.addr};
                c0         = cyc;
                mem_before = mem_req_count;
                predict_read(row.addr, exp_hit);
                exp_data = mem_word(row.addr.raw);
                @(posedge clk);
                req <= '{valid: 1'b0, addr: row.addr};
                waited = 0;
                while (!rsp.valid && waited < resp_limit) begin
                    @(posedge clk);
                    waited++;
                end
                // outputs read at an edge were set one edge earlier.
                if (!rsp.valid) begin
                    $display("no response to the read of %h within %0d cycles",
                             row.addr.raw, resp_limit);
                    count_error();
                    aborted = 1'b1;
                end else begin
                    if (rsp.hit != exp_hit) begin
                        $display("[ERROR] rsp.hit for %h: expected %h, got %h",
                                 row.addr.raw, exp_hit, rsp.hit);
                        count_error();
                    end
                    if (rsp.data != exp_data) begin
                        $display("[ERROR] rsp.data for %h: expected %h, got %h",
                                 row.addr.raw, exp_data, rsp.data);
                        count_error();
                    end
                    if (exp_hit && (mem_req_count != mem_before || mem_req.valid)) begin
                        $display("unexpected memory request on a hit to %h", row.addr.raw);
                        count_error();
                    end
                    if (exp_hit && cyc != c0 + 4) begin
                        $display("[ERROR] rsp.valid cycle for %h: expected %h, got %h",
                                 row.addr.raw, c0 + 4, cyc);
                        count_error();
                    end
                    if (!exp_hit && mem_req_count != mem_before + 1) begin
                        $display("expected one memory request for %h, saw %0d",
                                 row.addr.raw, mem_req_count - mem_before);
                        count_error();
                    end else if (!exp_hit) begin
                        if (mem_req_addr != row.addr.raw) begin
                            $display("[ERROR] mem_req.addr: expected %h, got %h",
                                     row.addr.raw, mem_req_addr);
                            count_error();
                        end
                        if (mem_req_cyc != c0 + 4) begin
                            $display("[ERROR] mem_req.valid cycle: expected %h, got %h",
                                     c0 + 4, mem_req_cyc);
                            count_error();
                        end
                        if (cyc != mem_rsp_cyc + 3) begin
                            $display("[ERROR] rsp.valid cycle after refill: expected %h, got %h",
                                     mem_rsp_cyc + 3, cyc);
                            count_error();
                        end
                    end
                end
            end
        end
        report_test();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0 && !aborted) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // the budget grows with the row count and the longest memory latency.
    initial begin
        int limit;
        wait (table_built);
        limit = rows.size() * (max_lat + 4) + reset_cycles;
        #(limit * clk_period);
        $display("watchdog: the run did not finish within %0d cycles", limit);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule : cache_tb

// ==== cache_top.f ====
cache_pkg.sv
plru.sv
lru_array.sv
tag_array.sv
data_array.sv
cache_ctrl.sv
cache_top.sv
cache_tb.sv

// ==== Makefile ====
SIM   := verilator
FLAGS := --binary --timing --assert
TOP   := cache_tb
FLIST := cache_top.f

SRCS := $(shell cat $(FLIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^PASS: all tests$$"

clean:
	rm -rf obj_dir
